//--- hdl/csr_index_pkg.sv
// Shared widths and buffer class codes; the class encoding must match the memory response source
package csr_index_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int index_width = 32;
    localparam int meta_width  = 16;
    localparam int class_width = 4;

    // --------------------------------------------------
    // Payload types
    // --------------------------------------------------
    // One index, or one bound of a range
    typedef logic [index_width-1:0] index_t;

    // Metadata carried from response to index
    typedef logic [meta_width-1:0] meta_t;

    // Buffer class of a memory response
    typedef logic [class_width-1:0] buffer_class_t;

    // --------------------------------------------------
    // Buffer class codes
    // --------------------------------------------------
    // Plain data responses, never turned into a configuration
    localparam buffer_class_t class_data = 4'h0;

    // Setup responses, each one holds a range
    localparam buffer_class_t class_cu_setup     = 4'h1;
    localparam buffer_class_t class_engine_setup = 4'h2;

endpackage : csr_index_pkg

//--- hdl/sync_fifo.sv
// Registered-read FIFO; fifo_depth must be a power of two, prog_thresh at most fifo_depth
module sync_fifo #(
    parameter int width       = 32,
    parameter int fifo_depth  = 32,
    parameter int prog_thresh = 16
) (
    input  logic             ap_clk,
    input  logic             srst,
    input  logic [width-1:0] din,
    input  logic             wr_en,
    input  logic             rd_en,
    output logic [width-1:0] dout,
    output logic             valid,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int addr_width  = $clog2(fifo_depth);
    localparam int count_width = addr_width + 1;

    localparam logic [count_width-1:0] depth_count  = count_width'(fifo_depth);
    localparam logic [count_width-1:0] thresh_count = count_width'(prog_thresh);

    // --------------------------------------------------
    // Storage and pointers
    // --------------------------------------------------
    logic [width-1:0]       mem [fifo_depth];
    logic [addr_width-1:0]  wr_ptr;
    logic [addr_width-1:0]  rd_ptr;
    logic [count_width-1:0] count;

    logic do_write;
    logic do_read;

    // Writes while full and reads while empty are dropped
    assign do_write = wr_en & ~full;
    assign do_read  = rd_en & ~empty;

    assign empty     = (count == '0);
    assign full      = (count == depth_count);
    assign prog_full = (count >= thresh_count);

    always_ff @(posedge ap_clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            valid  <= 1'b0;
        end else begin
            valid <= do_read;
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // --------------------------------------------------
    // Data path
    // --------------------------------------------------
    // Pointers wrap on their own, depth being a power of two
    always_ff @(posedge ap_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    // Read data lines up with valid, one cycle after rd_en
    always_ff @(posedge ap_clk) begin
        if (do_read) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule : sync_fifo

//--- hdl/csr_index_configure.sv
// Input has no back-pressure: a sender must not overrun the response FIFO; field 2 is ignored
module csr_index_configure
    import csr_index_pkg::*;
#(
    parameter int fifo_depth  = 32,
    parameter int prog_thresh = 16
) (
    input  logic          ap_clk,
    input  logic          areset_csr_index_generator,
    input  logic          resp_valid,
    input  buffer_class_t resp_class,
    input  meta_t         resp_meta,
    input  index_t        resp_field_0,
    input  index_t        resp_field_1,
    input  index_t        resp_field_2,
    input  index_t        resp_field_3,
    input  logic          cfg_prog_full,
    output logic          cfg_wr_en,
    output meta_t         cfg_meta,
    output index_t        cfg_index_start,
    output index_t        cfg_index_end,
    output index_t        cfg_array_size,
    output logic          setup_busy
);

    // Meta, start, end and array size
    localparam int resp_width = $bits(meta_t) + 3 * $bits(index_t);

    logic areset_configure;

    logic          resp_valid_reg;
    buffer_class_t resp_class_reg;
    meta_t         resp_meta_reg;
    index_t        resp_field_0_reg;
    index_t        resp_field_1_reg;
    index_t        resp_field_3_reg;

    logic                  resp_push;
    logic [resp_width-1:0] resp_din;
    logic [resp_width-1:0] resp_dout;
    logic                  resp_rd_en;
    logic                  resp_rd_valid;
    logic                  resp_empty;
    logic                  cfg_pending;

    meta_t  resp_out_meta;
    index_t resp_out_start;
    index_t resp_out_end;
    index_t resp_out_size;

    // --------------------------------------------------
    // Reset copy and setup status
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        areset_configure <= areset_csr_index_generator;
    end

    // Busy through reset and the cycle of its registered copy
    assign setup_busy = areset_csr_index_generator | areset_configure;

    // --------------------------------------------------
    // Input register
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_configure) begin
            resp_valid_reg <= 1'b0;
        end else begin
            resp_valid_reg <= resp_valid;
        end
    end

    // Field 2 has no part in a configuration and is not kept
    always_ff @(posedge ap_clk) begin
        resp_class_reg   <= resp_class;
        resp_meta_reg    <= resp_meta;
        resp_field_0_reg <= resp_field_0;
        resp_field_1_reg <= resp_field_1;
        resp_field_3_reg <= resp_field_3;
    end

    // --------------------------------------------------
    // Response FIFO
    // --------------------------------------------------
    // Only setup classes get queued
    assign resp_push = resp_valid_reg &
                       ((resp_class_reg == class_cu_setup) |
                        (resp_class_reg == class_engine_setup));
    assign resp_din  = {resp_meta_reg, resp_field_0_reg, resp_field_1_reg, resp_field_3_reg};

    // One entry in flight at a time, held off while downstream nears full
    assign resp_rd_en = ~resp_empty & ~cfg_pending & ~cfg_prog_full;

    sync_fifo #(
        .width       (resp_width),
        .fifo_depth  (fifo_depth),
        .prog_thresh (prog_thresh)
    ) u_resp_fifo (
        .ap_clk    (ap_clk),
        .srst      (areset_configure),
        .din       (resp_din),
        .wr_en     (resp_push),
        .rd_en     (resp_rd_en),
        .dout      (resp_dout),
        .valid     (resp_rd_valid),
        .empty     (resp_empty),
        .full      (),
        .prog_full ()
    );

    assign {resp_out_meta, resp_out_start, resp_out_end, resp_out_size} = resp_dout;

    // --------------------------------------------------
    // Configuration packet
    // --------------------------------------------------
    // Pending from the pop until the write pulse has gone out
    always_ff @(posedge ap_clk) begin
        if (areset_configure) begin
            cfg_pending <= 1'b0;
            cfg_wr_en   <= 1'b0;
        end else begin
            cfg_wr_en <= resp_rd_valid;
            if (resp_rd_en) begin
                cfg_pending <= 1'b1;
            end else if (cfg_wr_en) begin
                cfg_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (resp_rd_valid) begin
            cfg_meta        <= resp_out_meta;
            cfg_index_start <= resp_out_start;
            cfg_index_end   <= resp_out_end;
            cfg_array_size  <= resp_out_size;
        end
    end

endmodule : csr_index_configure

//--- hdl/csr_index_generator.sv
// Stride is fixed at one; a range with end at or below start is dropped without output
module csr_index_generator
    import csr_index_pkg::*;
(
    input  logic   ap_clk,
    input  logic   areset_csr_index_generator,
    input  logic   cfg_empty,
    input  logic   cfg_rd_valid,
    input  meta_t  cfg_meta,
    input  index_t cfg_index_start,
    input  index_t cfg_index_end,
    output logic   cfg_rd_en,
    input  logic   index_ready,
    output logic   index_valid,
    output index_t index_value,
    output meta_t  index_meta,
    output logic   index_last
);

    // --------------------------------------------------
    // State
    // --------------------------------------------------
    // Active while a range is being walked
    logic active;

    // A read went to the FIFO and its data are due
    logic fetch_wait;

    index_t index_end;
    index_t index_next;
    logic   range_ok;
    logic   transfer;

    // --------------------------------------------------
    // Configuration fetch
    // --------------------------------------------------
    // One request per idle period
    assign cfg_rd_en = ~cfg_empty & ~active & ~fetch_wait;

    assign range_ok = (cfg_index_end > cfg_index_start);

    // --------------------------------------------------
    // Output handshake
    // --------------------------------------------------
    assign index_valid = active;
    assign transfer    = index_valid & index_ready;
    assign index_next  = index_value + 1'b1;

    // Last index sits one below the end bound
    assign index_last = active & (index_next == index_end);

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            active     <= 1'b0;
            fetch_wait <= 1'b0;
        end else begin
            if (cfg_rd_en) begin
                fetch_wait <= 1'b1;
            end else if (cfg_rd_valid) begin
                fetch_wait <= 1'b0;
            end

            if (cfg_rd_valid & range_ok) begin
                active <= 1'b1;
            end else if (transfer & index_last) begin
                active <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Range registers
    // --------------------------------------------------
    // Data only move on a load or a transfer, so they hold under back-pressure
    always_ff @(posedge ap_clk) begin
        if (cfg_rd_valid) begin
            index_value <= cfg_index_start;
            index_end   <= cfg_index_end;
            index_meta  <= cfg_meta;
        end else if (transfer) begin
            index_value <= index_next;
        end
    end

endmodule : csr_index_generator

//--- hdl/csr_index_top.sv
// Latency varies with FIFO occupancy and back-pressure; array size is not forwarded
module csr_index_top
    import csr_index_pkg::*;
#(
    parameter int fifo_depth  = 32,
    parameter int prog_thresh = 16
) (
    input  logic          ap_clk,
    input  logic          areset_csr_index_generator,
    input  logic          resp_valid,
    input  buffer_class_t resp_class,
    input  meta_t         resp_meta,
    input  index_t        resp_field_0,
    input  index_t        resp_field_1,
    input  index_t        resp_field_2,
    input  index_t        resp_field_3,
    input  logic          index_ready,
    output logic          index_valid,
    output index_t        index_value,
    output meta_t         index_meta,
    output logic          index_last,
    output logic          setup_busy
);

    // Meta, start and end
    localparam int cfg_width = $bits(meta_t) + 2 * $bits(index_t);

    logic   cfg_wr_en;
    meta_t  cfg_wr_meta;
    index_t cfg_wr_start;
    index_t cfg_wr_end;
    logic   cfg_prog_full;

    logic [cfg_width-1:0] cfg_din;
    logic [cfg_width-1:0] cfg_dout;
    logic                 cfg_rd_en;
    logic                 cfg_rd_valid;
    logic                 cfg_empty;
    meta_t                cfg_rd_meta;
    index_t               cfg_rd_start;
    index_t               cfg_rd_end;

    // --------------------------------------------------
    // Configure stage
    // --------------------------------------------------
    csr_index_configure #(
        .fifo_depth  (fifo_depth),
        .prog_thresh (prog_thresh)
    ) u_configure (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .resp_valid                 (resp_valid),
        .resp_class                 (resp_class),
        .resp_meta                  (resp_meta),
        .resp_field_0               (resp_field_0),
        .resp_field_1               (resp_field_1),
        .resp_field_2               (resp_field_2),
        .resp_field_3               (resp_field_3),
        .cfg_prog_full              (cfg_prog_full),
        .cfg_wr_en                  (cfg_wr_en),
        .cfg_meta                   (cfg_wr_meta),
        .cfg_index_start            (cfg_wr_start),
        .cfg_index_end              (cfg_wr_end),
        .cfg_array_size             (),
        .setup_busy                 (setup_busy)
    );

    // --------------------------------------------------
    // Configuration FIFO
    // --------------------------------------------------
    assign cfg_din = {cfg_wr_meta, cfg_wr_start, cfg_wr_end};
    assign {cfg_rd_meta, cfg_rd_start, cfg_rd_end} = cfg_dout;

    sync_fifo #(
        .width       (cfg_width),
        .fifo_depth  (fifo_depth),
        .prog_thresh (prog_thresh)
    ) u_cfg_fifo (
        .ap_clk    (ap_clk),
        .srst      (areset_csr_index_generator),
        .din       (cfg_din),
        .wr_en     (cfg_wr_en),
        .rd_en     (cfg_rd_en),
        .dout      (cfg_dout),
        .valid     (cfg_rd_valid),
        .empty     (cfg_empty),
        .full      (),
        .prog_full (cfg_prog_full)
    );

    // --------------------------------------------------
    // Index generator
    // --------------------------------------------------
    csr_index_generator u_generator (
        .ap_clk                     (ap_clk),
        .areset_csr_index_generator (areset_csr_index_generator),
        .cfg_empty                  (cfg_empty),
        .cfg_rd_valid               (cfg_rd_valid),
        .cfg_meta                   (cfg_rd_meta),
        .cfg_index_start            (cfg_rd_start),
        .cfg_index_end              (cfg_rd_end),
        .cfg_rd_en                  (cfg_rd_en),
        .index_ready                (index_ready),
        .index_valid                (index_valid),
        .index_value                (index_value),
        .index_meta                 (index_meta),
        .index_last                 (index_last)
    );

endmodule : csr_index_top

//--- sim/csr_index_chk.sv
// Checks only the generator output handshake; all but the reset check are off during reset
module csr_index_chk
    import csr_index_pkg::*;
(
    input logic   ap_clk,
    input logic   areset_csr_index_generator,
    input logic   index_ready,
    input logic   index_valid,
    input index_t index_value,
    input meta_t  index_meta,
    input logic   index_last
);
    timeunit 1ns;
    timeprecision 100ps;

    // Failed assertions so far
    int fail_count = 0;

    // A held index keeps valid and all its data
    hold_stable: assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        (index_valid && !index_ready) |=>
            (index_valid && $stable(index_value) && $stable(index_meta) && $stable(index_last))
    ) else begin
        $error("index output changed while index_ready was low");
        fail_count++;
    end

    reset_clears_valid: assert property (
        @(posedge ap_clk) areset_csr_index_generator |=> !index_valid
    ) else begin
        $error("index_valid high in the cycle after reset");
        fail_count++;
    end

    // The transfer flagged last closes its range
    last_closes_range: assert property (
        @(posedge ap_clk) disable iff (areset_csr_index_generator)
        (index_valid && index_ready && index_last) |=> !index_valid
    ) else begin
        $error("index_valid still high after the transfer flagged last");
        fail_count++;
    end

endmodule : csr_index_chk

bind csr_index_generator csr_index_chk i_chk (
    .ap_clk                     (ap_clk),
    .areset_csr_index_generator (areset_csr_index_generator),
    .index_ready                (index_ready),
    .index_valid                (index_valid),
    .index_value                (index_value),
    .index_meta                 (index_meta),
    .index_last                 (index_last)
);

//--- sim/csr_index_tb.sv
// Sends at most 24 packets back to back, below the response FIFO depth; ranges stay short
module csr_index_tb
    import csr_index_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int fifo_depth  = 32;
    localparam int prog_thresh = 16;

    logic          ap_clk;
    logic          areset_csr_index_generator;
    logic          resp_valid;
    buffer_class_t resp_class;
    meta_t         resp_meta;
    index_t        resp_field_0;
    index_t        resp_field_1;
    index_t        resp_field_2;
    index_t        resp_field_3;
    logic          index_ready;
    logic          index_valid;
    index_t        index_value;
    meta_t         index_meta;
    logic          index_last;
    logic          setup_busy;

    // Reference model, one entry per expected transfer
    index_t exp_value [$];
    meta_t  exp_meta [$];
    logic   exp_last [$];

    integer seed = 74378;
    int error_count = 0;
    int test_count = 0;
    int failed_tests = 0;
    int cycle_count = 0;
    int cycle_limit = 200;
    logic saw_prog_full = 1'b0;

    csr_index_top #(
        .fifo_depth  (fifo_depth),
        .prog_thresh (prog_thresh)
    ) i_dut (.*);

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // --------------------------------------------------
    // Timeout and output monitor
    // --------------------------------------------------
    always @(posedge ap_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d indices still missing",
                     cycle_count, exp_value.size());
            $display("Simulation FAILED");
            $finish;
        end
    end

    always @(posedge ap_clk) begin
        if (i_dut.cfg_prog_full === 1'b1) begin
            saw_prog_full = 1'b1;
        end
        if (!areset_csr_index_generator && index_valid === 1'b1 && index_ready === 1'b1) begin
            if (exp_value.size() == 0) begin
                $display("Unexpected index %0d at %0t when none was due", index_value, $time);
                error_count++;
            end else begin
                if (index_value !== exp_value[0] || index_meta !== exp_meta[0] ||
                    index_last !== exp_last[0]) begin
                    $display("ERROR %0t: got index %0d meta %h last %b, expected %0d %h %b",
                             $time, index_value, index_meta, index_last,
                             exp_value[0], exp_meta[0], exp_last[0]);
                    error_count++;
                end
                void'(exp_value.pop_front());
                void'(exp_meta.pop_front());
                void'(exp_last.pop_front());
            end
        end
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    // Setup classes give start up to end minus one, anything else gives nothing
    function automatic void expect_range(input buffer_class_t cls, input meta_t meta,
                                         input index_t first, input index_t bound);
        index_t i;
        if ((cls != class_cu_setup) && (cls != class_engine_setup)) begin
            return;
        end
        i = first;
        while (i < bound) begin
            exp_value.push_back(i);
            exp_meta.push_back(meta);
            exp_last.push_back(i == bound - 32'd1);
            cycle_limit = cycle_limit + 8;
            i = i + 32'd1;
        end
    endfunction

    task automatic send_packet(input buffer_class_t cls, input index_t first,
                               input index_t bound);
        meta_t meta;
        meta = meta_t'($random(seed));
        @(negedge ap_clk);
        resp_valid   = 1'b1;
        resp_class   = cls;
        resp_meta    = meta;
        resp_field_0 = first;
        resp_field_1 = bound;
        resp_field_2 = $random(seed);
        resp_field_3 = $random(seed);
        expect_range(cls, meta, first, bound);
        cycle_limit = cycle_limit + 20;
    endtask

    // Range length 0 to 8
    task automatic send_random_packet(input buffer_class_t cls);
        index_t first;
        index_t len;
        first = {$random(seed)} % 32'd4096;
        len   = {$random(seed)} % 32'd9;
        send_packet(cls, first, first + len);
    endtask

    task automatic stop_input();
        @(negedge ap_clk);
        resp_valid = 1'b0;
    endtask

    task automatic wait_drained(input bit random_ready);
        while (exp_value.size() != 0) begin
            @(negedge ap_clk);
            if (random_ready) begin
                index_ready = ($random(seed) & 32'd1) != 0;
            end
        end
        index_ready = 1'b1;
        repeat (10) @(negedge ap_clk);
        if (index_valid !== 1'b0) begin
            $display("index_valid still high at %0t after the last expected index", $time);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count != errors_before) begin
            failed_tests++;
            $display("Test %s failed with %0d errors", name, error_count - errors_before);
        end else begin
            $display("Test %s passed", name);
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic check_reset();
        int errors_before;
        errors_before = error_count;
        repeat (10) begin
            @(negedge ap_clk);
            if (setup_busy !== 1'b1) begin
                $display("ERROR %0t: setup_busy low during reset", $time);
                error_count++;
            end
        end
        areset_csr_index_generator = 1'b0;
        @(negedge ap_clk);
        if (setup_busy !== 1'b0) begin
            $display("ERROR %0t: setup_busy still high after reset", $time);
            error_count++;
        end
        repeat (20) begin
            @(negedge ap_clk);
            if (index_valid !== 1'b0) begin
                $display("ERROR %0t: index_valid high before any packet", $time);
                error_count++;
            end
        end
        finish_test("reset", errors_before);
    endtask

    task automatic run_single_range();
        int errors_before;
        errors_before = error_count;
        send_packet(class_cu_setup, 32'd5, 32'd9);
        stop_input();
        wait_drained(1'b0);
        finish_test("single_range", errors_before);
    endtask

    task automatic run_filtering();
        int errors_before;
        errors_before = error_count;
        send_packet(class_data, 32'd0, 32'd4);
        send_packet(class_data, 32'd10, 32'd20);
        send_packet(class_cu_setup, 32'd7, 32'd7);
        send_packet(class_engine_setup, 32'd9, 32'd3);
        send_packet(class_engine_setup, 32'd100, 32'd103);
        stop_input();
        wait_drained(1'b0);
        finish_test("filtering", errors_before);
    endtask

    task automatic run_backpressure();
        int errors_before;
        int n;
        errors_before = error_count;
        for (n = 0; n < 6; n++) begin
            send_random_packet(n[0] ? class_engine_setup : class_cu_setup);
        end
        stop_input();
        wait_drained(1'b1);
        finish_test("backpressure", errors_before);
    endtask

    // Ready held low so the configuration FIFO fills past its threshold
    task automatic run_burst();
        int errors_before;
        int n;
        int waited;
        errors_before = error_count;
        saw_prog_full = 1'b0;
        index_ready = 1'b0;
        for (n = 0; n < 24; n++) begin
            send_random_packet(n[0] ? class_engine_setup : class_cu_setup);
        end
        stop_input();
        waited = 0;
        while (!saw_prog_full && waited < 120) begin
            @(negedge ap_clk);
            waited++;
        end
        if (!saw_prog_full) begin
            $display("Configuration FIFO never reached its programmable full level");
            error_count++;
        end
        index_ready = 1'b1;
        wait_drained(1'b0);
        finish_test("burst", errors_before);
    endtask

    initial begin
        areset_csr_index_generator = 1'b1;
        resp_valid   = 1'b0;
        resp_class   = class_data;
        resp_meta    = '0;
        resp_field_0 = '0;
        resp_field_1 = '0;
        resp_field_2 = '0;
        resp_field_3 = '0;
        index_ready  = 1'b1;

        check_reset();
        run_single_range();
        run_filtering();
        run_backpressure();
        run_burst();

        $display("Summary: %0d tests, %0d failed, %0d errors, %0d assertion failures",
                 test_count, failed_tests, error_count, i_dut.u_generator.i_chk.fail_count);
        if (error_count == 0 && i_dut.u_generator.i_chk.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : csr_index_tb

//--- csr_index.f
hdl/csr_index_pkg.sv
hdl/sync_fifo.sv
hdl/csr_index_configure.sv
hdl/csr_index_generator.sv
hdl/csr_index_top.sv
sim/csr_index_chk.sv
sim/csr_index_tb.sv

//--- Makefile
# Verilator build and run for the CSR index testbench

VERILATOR ?= verilator
TOP       ?= csr_index_tb
FILELIST  ?= csr_index.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "Run failed"; exit 1; fi
	@if ! grep -q "Simulation PASSED" $(LOG); then echo "Run ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
